// ==== sources.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
common/exe_ports_if.sv
dispatch/issue_dispatch.sv
writeback/wb_arbiter.sv
verilog/exe_stage_top.sv
test/tb_exe_stage.sv

// ==== test/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage import isa_pkg::*, pipe_pkg::*; ();

    localparam int BUNDLE_W    = 160;  // Operand bundle without its valid
    localparam int SLOT_W      = 139;  // Valid, data, rd, sid, redirect, redirect_pc
    localparam int STIM_CYCLES = 240;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       lane_valid_i     [NUM_LANES];
    unit_mask_t lane_unit_mask_i [NUM_LANES];
    logic       lane_rs1_valid_i [NUM_LANES];
    logic       lane_rs2_valid_i [NUM_LANES];
    reg_idx_t   lane_rs1_i       [NUM_LANES];
    reg_idx_t   lane_rs2_i       [NUM_LANES];
    reg_idx_t   lane_rd_i        [NUM_LANES];
    xword_t     lane_rs1_value_i [NUM_LANES];
    xword_t     lane_rs2_value_i [NUM_LANES];
    rd_type_t   lane_rd_type_i   [NUM_LANES];
    func_code_t lane_func_code_i [NUM_LANES];
    func3_t     lane_func3_i     [NUM_LANES];
    func2_t     lane_func2_i     [NUM_LANES];
    sid_t       lane_sid_i       [NUM_LANES];
    logic       exe_valid_o      [NUM_UNITS];
    logic       exe_rs1_valid_o  [NUM_UNITS];
    reg_idx_t   exe_rs1_o        [NUM_UNITS];
    xword_t     exe_rs1_value_o  [NUM_UNITS];
    logic       exe_rs2_valid_o  [NUM_UNITS];
    reg_idx_t   exe_rs2_o        [NUM_UNITS];
    xword_t     exe_rs2_value_o  [NUM_UNITS];
    reg_idx_t   exe_rd_o         [NUM_UNITS];
    rd_type_t   exe_rd_type_o    [NUM_UNITS];
    func_code_t exe_func_code_o  [NUM_UNITS];
    func3_t     exe_func3_o      [NUM_UNITS];
    func2_t     exe_func2_o      [NUM_UNITS];
    sid_t       exe_sid_o        [NUM_UNITS];
    logic       res_valid_i      [NUM_UNITS];
    logic       res_stall_i      [NUM_UNITS];
    xword_t     res_rd_value_i   [NUM_UNITS];
    reg_idx_t   res_rd_i         [NUM_UNITS];
    sid_t       res_sid_i        [NUM_UNITS];
    logic       beu_redirect_i;
    xword_t     beu_redirect_pc_i;
    logic       wb_valid_o       [NUM_LANES];
    xword_t     wb_data_o        [NUM_LANES];
    reg_idx_t   wb_rd_o          [NUM_LANES];
    sid_t       wb_sid_o         [NUM_LANES];
    logic       wb_redirect_o    [NUM_LANES];
    xword_t     wb_redirect_pc_o [NUM_LANES];

    logic                checking = 1'b0;
    logic                exp_valid  [NUM_UNITS];
    logic [BUNDLE_W-1:0] exp_bundle [NUM_UNITS];
    logic [BUNDLE_W-1:0] act_bundle [NUM_UNITS];
    logic [SLOT_W-1:0]   exp_slot   [NUM_LANES];
    logic [SLOT_W-1:0]   act_slot   [NUM_LANES];
    string               test_name = "reset";
    int                  error_count = 0;
    int                  errors_at_start = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    int                  cycle_count = 0;

    exe_stage_top exe_stage_top_inst (.*);

    always #10 clk = ~clk;

    function automatic logic [BUNDLE_W-1:0] lane_bundle(int l);
        return {lane_rs1_valid_i[l], lane_rs1_i[l], lane_rs1_value_i[l], lane_rs2_valid_i[l],
                lane_rs2_i[l], lane_rs2_value_i[l], lane_rd_i[l], lane_rd_type_i[l],
                lane_func_code_i[l], lane_func3_i[l], lane_func2_i[l], lane_sid_i[l]};
    endfunction

    function automatic logic [SLOT_W-1:0] result_word(int u);
        logic   redirect;
        xword_t pc;
        redirect = (u == UNIT_BEU) ? beu_redirect_i : 1'b0;
        pc       = (u == UNIT_BEU) ? beu_redirect_pc_i : '0;
        return {1'b1, res_rd_value_i[u], res_rd_i[u], res_sid_i[u], redirect, pc};
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    always @(posedge clk) begin
        logic sel0;
        logic sel1;
        int   slot;
        for (int u = 0; u < NUM_UNITS; u++) begin
            sel0 = lane_valid_i[0] && lane_unit_mask_i[0][u];
            sel1 = lane_valid_i[1] && lane_unit_mask_i[1][u];
            exp_valid[u]  <= !reset_i && (sel0 || sel1);
            exp_bundle[u] <= sel0 ? lane_bundle(0) : lane_bundle(1);  // Lane 0 wins a shared unit
        end
        for (int s = 0; s < NUM_LANES; s++) begin
            exp_slot[s] <= '0;
        end
        slot = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (!reset_i && res_valid_i[u] && !res_stall_i[u] && slot < NUM_LANES) begin
                exp_slot[slot] <= result_word(u);
                slot++;
            end
        end
    end

    task automatic report_mismatch(string what, int idx, logic [BUNDLE_W-1:0] expected,
                                   logic [BUNDLE_W-1:0] actual);
        $display("Mismatch test=%s %s[%0d] expected=%h actual=%h",
                 test_name, what, idx, expected, actual);
        error_count++;
    endtask

    // Outputs only move on the rising edge, so the falling edge sees them settled
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_check_unit
        assign act_bundle[u] = {exe_rs1_valid_o[u], exe_rs1_o[u], exe_rs1_value_o[u],
                                exe_rs2_valid_o[u], exe_rs2_o[u], exe_rs2_value_o[u],
                                exe_rd_o[u], exe_rd_type_o[u], exe_func_code_o[u],
                                exe_func3_o[u], exe_func2_o[u], exe_sid_o[u]};
        assert property (@(negedge clk) checking |-> exe_valid_o[u] == exp_valid[u])
            else report_mismatch("exe_valid", u, exp_valid[u], exe_valid_o[u]);
        assert property (@(negedge clk) checking && exp_valid[u] |-> act_bundle[u] == exp_bundle[u])
            else report_mismatch("exe_bundle", u, exp_bundle[u], act_bundle[u]);
    end

    for (genvar s = 0; s < NUM_LANES; s++) begin : g_check_slot
        assign act_slot[s] = {wb_valid_o[s], wb_data_o[s], wb_rd_o[s], wb_sid_o[s],
                              wb_redirect_o[s], wb_redirect_pc_o[s]};
        assert property (@(negedge clk) checking |-> act_slot[s] == exp_slot[s])
            else report_mismatch("wb_slot", s, exp_slot[s], act_slot[s]);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic idle_inputs();
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_valid_i[l]     = 1'b0;
            lane_unit_mask_i[l] = '0;
            lane_rs1_valid_i[l] = 1'b0;
            lane_rs2_valid_i[l] = 1'b0;
            lane_rs1_i[l]       = '0;
            lane_rs2_i[l]       = '0;
            lane_rd_i[l]        = '0;
            lane_rs1_value_i[l] = '0;
            lane_rs2_value_i[l] = '0;
            lane_rd_type_i[l]   = '0;
            lane_func_code_i[l] = '0;
            lane_func3_i[l]     = '0;
            lane_func2_i[l]     = '0;
            lane_sid_i[l]       = '0;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            res_valid_i[u]    = 1'b0;
            res_stall_i[u]    = 1'b0;
            res_rd_value_i[u] = '0;
            res_rd_i[u]       = '0;
            res_sid_i[u]      = '0;
        end
        beu_redirect_i    = 1'b0;
        beu_redirect_pc_i = '0;
    endtask

    task automatic random_lane(int l, logic valid, unit_mask_t mask);
        lane_valid_i[l]     = valid;
        lane_unit_mask_i[l] = mask;
        lane_rs1_valid_i[l] = $urandom;
        lane_rs2_valid_i[l] = $urandom;
        lane_rs1_i[l]       = $urandom;
        lane_rs2_i[l]       = $urandom;
        lane_rd_i[l]        = $urandom;
        lane_rs1_value_i[l] = {$urandom, $urandom};
        lane_rs2_value_i[l] = {$urandom, $urandom};
        lane_rd_type_i[l]   = $urandom;
        lane_func_code_i[l] = $urandom;
        lane_func3_i[l]     = $urandom;
        lane_func2_i[l]     = $urandom;
        lane_sid_i[l]       = $urandom;
    endtask

    task automatic random_result(int u, logic valid, logic stall);
        res_valid_i[u]    = valid;
        res_stall_i[u]    = stall;
        res_rd_value_i[u] = {$urandom, $urandom};
        res_rd_i[u]       = $urandom;
        res_sid_i[u]      = $urandom;
    endtask

    task automatic start_test(string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    // The last stimulus is checked at the next falling edge, so tally one edge later
    task automatic finish_test();
        @(negedge clk);
        idle_inputs();
        @(posedge clk);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d mismatches", test_name, error_count - errors_at_start);
        end
    endtask

    function automatic unit_mask_t one_hot(int u);
        return unit_mask_t'(1 << u);
    endfunction

    // ------------------------------
    // Tests
    // ------------------------------
    initial begin
        logic [NUM_UNITS-1:0] alt;
        void'($urandom(87591));
        idle_inputs();
        reset_i = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(posedge clk);
        checking = 1'b1;

        start_test("idle_after_reset");
        @(negedge clk);
        finish_test();

        start_test("lanes_to_different_units");
        @(negedge clk);
        random_lane(0, 1'b1, one_hot(UNIT_BEU));
        random_lane(1, 1'b1, one_hot(UNIT_ALU1));
        @(negedge clk);
        random_lane(0, 1'b1, one_hot(UNIT_LSU));
        random_lane(1, 1'b1, one_hot(UNIT_ALU0));
        finish_test();

        start_test("lanes_to_same_unit");
        @(negedge clk);
        random_lane(0, 1'b1, one_hot(UNIT_ALU0));
        random_lane(1, 1'b1, one_hot(UNIT_ALU0));
        @(negedge clk);
        random_lane(0, 1'b1, one_hot(UNIT_LSU));
        random_lane(1, 1'b1, one_hot(UNIT_LSU));
        finish_test();

        start_test("writeback_priority");
        for (int p = 0; p < 16; p++) begin
            @(negedge clk);
            alt = p[0] ? 4'b1111 : 4'b0101;  // Non-eligible units are idle or stalled
            for (int u = 0; u < NUM_UNITS; u++) begin
                random_result(u, p[u] | alt[u], !p[u] && alt[u]);
            end
            beu_redirect_i    = $urandom;
            beu_redirect_pc_i = {$urandom, $urandom};
        end
        finish_test();

        start_test("beu_redirect");
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            idle_inputs();
            random_result(UNIT_BEU, 1'b1, 1'b0);
            random_result(c == 0 ? UNIT_LSU : UNIT_ALU0, 1'b1, 1'b0);
            if (c == 2) begin
                random_result(UNIT_ALU1, 1'b1, 1'b0);  // BEU loses both slots here
            end
            beu_redirect_i    = 1'b1;
            beu_redirect_pc_i = {$urandom, $urandom};
        end
        finish_test();

        start_test("random_traffic");
        repeat (200) begin
            @(negedge clk);
            for (int l = 0; l < NUM_LANES; l++) begin
                random_lane(l, $urandom, one_hot($urandom % NUM_UNITS));
            end
            for (int u = 0; u < NUM_UNITS; u++) begin
                random_result(u, $urandom, $urandom);
            end
            beu_redirect_i    = $urandom;
            beu_redirect_pc_i = {$urandom, $urandom};
        end
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/exe_stage_top.sv ====
`timescale 1ns/1ps

module exe_stage_top import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,

    // Issue lanes
    input  logic       lane_valid_i     [NUM_LANES],
    input  unit_mask_t lane_unit_mask_i [NUM_LANES],
    input  logic       lane_rs1_valid_i [NUM_LANES],
    input  logic       lane_rs2_valid_i [NUM_LANES],
    input  reg_idx_t   lane_rs1_i       [NUM_LANES],
    input  reg_idx_t   lane_rs2_i       [NUM_LANES],
    input  reg_idx_t   lane_rd_i        [NUM_LANES],
    input  xword_t     lane_rs1_value_i [NUM_LANES],
    input  xword_t     lane_rs2_value_i [NUM_LANES],
    input  rd_type_t   lane_rd_type_i   [NUM_LANES],
    input  func_code_t lane_func_code_i [NUM_LANES],
    input  func3_t     lane_func3_i     [NUM_LANES],
    input  func2_t     lane_func2_i     [NUM_LANES],
    input  sid_t       lane_sid_i       [NUM_LANES],

    // Operands to the execution units
    output logic       exe_valid_o      [NUM_UNITS],
    output logic       exe_rs1_valid_o  [NUM_UNITS],
    output reg_idx_t   exe_rs1_o        [NUM_UNITS],
    output xword_t     exe_rs1_value_o  [NUM_UNITS],
    output logic       exe_rs2_valid_o  [NUM_UNITS],
    output reg_idx_t   exe_rs2_o        [NUM_UNITS],
    output xword_t     exe_rs2_value_o  [NUM_UNITS],
    output reg_idx_t   exe_rd_o         [NUM_UNITS],
    output rd_type_t   exe_rd_type_o    [NUM_UNITS],
    output func_code_t exe_func_code_o  [NUM_UNITS],
    output func3_t     exe_func3_o      [NUM_UNITS],
    output func2_t     exe_func2_o      [NUM_UNITS],
    output sid_t       exe_sid_o        [NUM_UNITS],

    // Results from the execution units
    input  logic       res_valid_i      [NUM_UNITS],
    input  logic       res_stall_i      [NUM_UNITS],
    input  xword_t     res_rd_value_i   [NUM_UNITS],
    input  reg_idx_t   res_rd_i         [NUM_UNITS],
    input  sid_t       res_sid_i        [NUM_UNITS],
    input  logic       beu_redirect_i,
    input  xword_t     beu_redirect_pc_i,

    // Writeback slots
    output logic       wb_valid_o       [NUM_LANES],
    output xword_t     wb_data_o        [NUM_LANES],
    output reg_idx_t   wb_rd_o          [NUM_LANES],
    output sid_t       wb_sid_o         [NUM_LANES],
    output logic       wb_redirect_o    [NUM_LANES],
    output xword_t     wb_redirect_pc_o [NUM_LANES]
);

    unit_issue_if  issue_bus  [NUM_UNITS] ();
    unit_result_if result_bus [NUM_UNITS] ();

    issue_dispatch issue_dispatch_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .lane_valid_i     (lane_valid_i),
        .lane_unit_mask_i (lane_unit_mask_i),
        .lane_rs1_valid_i (lane_rs1_valid_i),
        .lane_rs2_valid_i (lane_rs2_valid_i),
        .lane_rs1_i       (lane_rs1_i),
        .lane_rs2_i       (lane_rs2_i),
        .lane_rd_i        (lane_rd_i),
        .lane_rs1_value_i (lane_rs1_value_i),
        .lane_rs2_value_i (lane_rs2_value_i),
        .lane_rd_type_i   (lane_rd_type_i),
        .lane_func_code_i (lane_func_code_i),
        .lane_func3_i     (lane_func3_i),
        .lane_func2_i     (lane_func2_i),
        .lane_sid_i       (lane_sid_i),
        .unit_o           (issue_bus)
    );

    // ------------------------------
    // Per-unit port mapping
    // ------------------------------
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        assign exe_valid_o[u]     = issue_bus[u].valid;
        assign exe_rs1_valid_o[u] = issue_bus[u].rs1_valid;
        assign exe_rs1_o[u]       = issue_bus[u].rs1;
        assign exe_rs1_value_o[u] = issue_bus[u].rs1_value;
        assign exe_rs2_valid_o[u] = issue_bus[u].rs2_valid;
        assign exe_rs2_o[u]       = issue_bus[u].rs2;
        assign exe_rs2_value_o[u] = issue_bus[u].rs2_value;
        assign exe_rd_o[u]        = issue_bus[u].rd;
        assign exe_rd_type_o[u]   = issue_bus[u].rd_type;
        assign exe_func_code_o[u] = issue_bus[u].func_code;
        assign exe_func3_o[u]     = issue_bus[u].func3;
        assign exe_func2_o[u]     = issue_bus[u].func2;
        assign exe_sid_o[u]       = issue_bus[u].sid;

        assign result_bus[u].valid    = res_valid_i[u];
        assign result_bus[u].stall    = res_stall_i[u];
        assign result_bus[u].rd_value = res_rd_value_i[u];
        assign result_bus[u].rd       = res_rd_i[u];
        assign result_bus[u].sid      = res_sid_i[u];

        if (u == UNIT_BEU) begin : g_redirect
            assign result_bus[u].redirect    = beu_redirect_i;
            assign result_bus[u].redirect_pc = beu_redirect_pc_i;
        end else begin : g_no_redirect
            assign result_bus[u].redirect    = 1'b0;  // Branches resolve in the BEU only
            assign result_bus[u].redirect_pc = '0;
        end
    end

    wb_arbiter wb_arbiter_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .unit_i           (result_bus),
        .wb_valid_o       (wb_valid_o),
        .wb_data_o        (wb_data_o),
        .wb_rd_o          (wb_rd_o),
        .wb_sid_o         (wb_sid_o),
        .wb_redirect_o    (wb_redirect_o),
        .wb_redirect_pc_o (wb_redirect_pc_o)
    );

endmodule

// ==== writeback/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    unit_result_if.dst unit_i           [NUM_UNITS],
    output logic       wb_valid_o       [NUM_LANES],
    output xword_t     wb_data_o        [NUM_LANES],
    output reg_idx_t   wb_rd_o          [NUM_LANES],
    output sid_t       wb_sid_o         [NUM_LANES],
    output logic       wb_redirect_o    [NUM_LANES],
    output xword_t     wb_redirect_pc_o [NUM_LANES]
);

    logic [NUM_UNITS-1:0] eligible;
    logic [NUM_UNITS-1:0] unit_redirect;
    xword_t               unit_data        [NUM_UNITS];
    reg_idx_t             unit_rd          [NUM_UNITS];
    sid_t                 unit_sid         [NUM_UNITS];
    xword_t               unit_redirect_pc [NUM_UNITS];

    unit_mask_t grant [NUM_LANES];  // One-hot per slot, all zero when the slot is empty

    xword_t   slot_data        [NUM_LANES];
    reg_idx_t slot_rd          [NUM_LANES];
    sid_t     slot_sid         [NUM_LANES];
    logic     slot_redirect    [NUM_LANES];
    xword_t   slot_redirect_pc [NUM_LANES];

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        assign eligible[u]         = unit_i[u].valid & ~unit_i[u].stall;
        assign unit_data[u]        = unit_i[u].rd_value;
        assign unit_rd[u]          = unit_i[u].rd;
        assign unit_sid[u]         = unit_i[u].sid;
        assign unit_redirect[u]    = unit_i[u].redirect;
        assign unit_redirect_pc[u] = unit_i[u].redirect_pc;
    end

    // ------------------------------
    // Priority scan
    // ------------------------------
    // Eligible units fill the slots in unit index order
    always_comb begin
        int found;
        found = 0;
        for (int s = 0; s < NUM_LANES; s++) begin
            grant[s] = '0;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (eligible[u] && found < NUM_LANES) begin
                grant[found][u] = 1'b1;
                found++;
            end
        end
    end

    // Redirect lines are low on all units but the BEU, so the same AND-OR serves them
    always_comb begin
        for (int s = 0; s < NUM_LANES; s++) begin
            slot_data[s]        = '0;
            slot_rd[s]          = '0;
            slot_sid[s]         = '0;
            slot_redirect[s]    = 1'b0;
            slot_redirect_pc[s] = '0;
            for (int u = 0; u < NUM_UNITS; u++) begin
                slot_data[s]        |= {XLEN{grant[s][u]}} & unit_data[u];
                slot_rd[s]          |= {REG_IDX_W{grant[s][u]}} & unit_rd[u];
                slot_sid[s]         |= {SID_W{grant[s][u]}} & unit_sid[u];
                slot_redirect[s]    |= grant[s][u] & unit_redirect[u];
                slot_redirect_pc[s] |= {XLEN{grant[s][u]}} & unit_redirect_pc[u];
            end
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_LANES; s++) begin
            if (reset_i) begin
                wb_valid_o[s]    <= 1'b0;
                wb_redirect_o[s] <= 1'b0;
            end else begin
                wb_valid_o[s]    <= |grant[s];
                wb_redirect_o[s] <= slot_redirect[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_LANES; s++) begin
            wb_data_o[s]        <= slot_data[s];
            wb_rd_o[s]          <= slot_rd[s];
            wb_sid_o[s]         <= slot_sid[s];
            wb_redirect_pc_o[s] <= slot_redirect_pc[s];
        end
    end

endmodule

// ==== dispatch/issue_dispatch.sv ====
`timescale 1ns/1ps

module issue_dispatch import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       lane_valid_i     [NUM_LANES],
    input  unit_mask_t lane_unit_mask_i [NUM_LANES],
    input  logic       lane_rs1_valid_i [NUM_LANES],
    input  logic       lane_rs2_valid_i [NUM_LANES],
    input  reg_idx_t   lane_rs1_i       [NUM_LANES],
    input  reg_idx_t   lane_rs2_i       [NUM_LANES],
    input  reg_idx_t   lane_rd_i        [NUM_LANES],
    input  xword_t     lane_rs1_value_i [NUM_LANES],
    input  xword_t     lane_rs2_value_i [NUM_LANES],
    input  rd_type_t   lane_rd_type_i   [NUM_LANES],
    input  func_code_t lane_func_code_i [NUM_LANES],
    input  func3_t     lane_func3_i     [NUM_LANES],
    input  func2_t     lane_func2_i     [NUM_LANES],
    input  sid_t       lane_sid_i       [NUM_LANES],
    unit_issue_if.src  unit_o           [NUM_UNITS]
);

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        logic [NUM_LANES-1:0] lane_sel;  // Lanes aiming at this unit
        int unsigned          pick;      // Lane whose bundle feeds the unit

        always_comb begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_sel[l] = lane_valid_i[l] & lane_unit_mask_i[l][u];
            end
        end

        // The lowest selecting lane wins and a losing lane's bundle is dropped
        // With no lane selecting, the mux rests on the last lane
        always_comb begin
            pick = NUM_LANES - 1;
            for (int l = NUM_LANES - 1; l >= 0; l--) begin
                if (lane_sel[l]) begin
                    pick = l;
                end
            end
        end

        // ------------------------------
        // Stage register
        // ------------------------------
        always_ff @(posedge clk) begin
            if (reset_i) begin
                unit_o[u].valid <= 1'b0;
            end else begin
                unit_o[u].valid <= |lane_sel;
            end
        end

        always_ff @(posedge clk) begin
            unit_o[u].rs1_valid <= lane_rs1_valid_i[pick];
            unit_o[u].rs1       <= lane_rs1_i[pick];
            unit_o[u].rs1_value <= lane_rs1_value_i[pick];
            unit_o[u].rs2_valid <= lane_rs2_valid_i[pick];
            unit_o[u].rs2       <= lane_rs2_i[pick];
            unit_o[u].rs2_value <= lane_rs2_value_i[pick];
            unit_o[u].rd        <= lane_rd_i[pick];
            unit_o[u].rd_type   <= lane_rd_type_i[pick];
            unit_o[u].func_code <= lane_func_code_i[pick];
            unit_o[u].func3     <= lane_func3_i[pick];
            unit_o[u].func2     <= lane_func2_i[pick];
            unit_o[u].sid       <= lane_sid_i[pick];
        end
    end

endmodule

// ==== common/exe_ports_if.sv ====
`timescale 1ns/1ps

// Operand bundle handed to one execution unit
interface unit_issue_if import isa_pkg::*, pipe_pkg::*; ();

    logic       valid;
    logic       rs1_valid;
    reg_idx_t   rs1;
    xword_t     rs1_value;
    logic       rs2_valid;
    reg_idx_t   rs2;
    xword_t     rs2_value;
    reg_idx_t   rd;
    rd_type_t   rd_type;
    func_code_t func_code;
    func3_t     func3;
    func2_t     func2;
    sid_t       sid;

    modport src (
        output valid, rs1_valid, rs1, rs1_value, rs2_valid, rs2, rs2_value,
        output rd, rd_type, func_code, func3, func2, sid
    );

    modport dst (
        input valid, rs1_valid, rs1, rs1_value, rs2_valid, rs2, rs2_value,
        input rd, rd_type, func_code, func3, func2, sid
    );

endinterface

// Result offered by one execution unit for writeback
interface unit_result_if import isa_pkg::*, pipe_pkg::*; ();

    logic     valid;
    logic     stall;        // Unit holds its result this cycle
    xword_t   rd_value;
    reg_idx_t rd;
    sid_t     sid;
    logic     redirect;
    xword_t   redirect_pc;

    modport src (output valid, stall, rd_value, rd, sid, redirect, redirect_pc);
    modport dst (input valid, stall, rd_value, rd, sid, redirect, redirect_pc);

endinterface

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    // ------------------------------
    // Issue and writeback width
    // ------------------------------
    localparam int NUM_LANES = 2;  // Issue lanes and writeback slots alike
    localparam int NUM_UNITS = 4;

    // ------------------------------
    // Execution units
    // ------------------------------
    // The index is the bit in the unit mask and also the writeback priority,
    // with unit 0 served first
    localparam int UNIT_ALU0 = 0;
    localparam int UNIT_ALU1 = 1;
    localparam int UNIT_BEU  = 2;  // Only unit that can redirect the front end
    localparam int UNIT_LSU  = 3;

    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    // ------------------------------
    // Scoreboard
    // ------------------------------
    localparam int SB_IDX_W = 3;
    localparam int SID_W    = SB_IDX_W + 1;  // Wrap bit on top of the entry index

    typedef logic [SID_W-1:0] sid_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

    // ------------------------------
    // Register file
    // ------------------------------
    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      xword_t;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    localparam int RD_TYPE_W   = 2;
    localparam int FUNC_CODE_W = 4;  // Operation code as each unit decodes it
    localparam int FUNC3_W     = 3;
    localparam int FUNC2_W     = 2;

    // Integer, float or no destination at all
    typedef logic [RD_TYPE_W-1:0] rd_type_t;

    typedef logic [FUNC_CODE_W-1:0] func_code_t;
    typedef logic [FUNC3_W-1:0]     func3_t;
    typedef logic [FUNC2_W-1:0]     func2_t;

endpackage
